// ==== sim.f ====
+incdir+design
design/ccu_pkg.sv
design/ccu_read_fsm.sv
design/ccu_snoop_collector.sv
design/ccu_beat_counter.sv
design/ccu_line_buffer.sv
design/ccu_top.sv
tests/ccu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ccu testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module ccu_tb -o ccu_sim \
    && ./obj_dir/ccu_sim | tee /dev/stderr | grep -qx ">>> PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/ccu_tb.sv ====
`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_tb import ccu_pkg::*; ();

    localparam int NROWS = 6;
    localparam int NP = `CCU_NUM_PORTS;

    logic clk_i;
    logic rst_ni;
    logic ar_valid_i, ar_ready_o, ar_len_i;
    addr_t ar_addr_i;
    id_t ar_id_i;
    snoop_t ar_snoop_i;
    logic r_valid_o, r_ready_i, r_last_o, r_shared_o, r_dirty_o;
    data_t r_data_o;
    id_t r_id_o;
    port_mask_t ac_valid_o, ac_ready_i, cr_valid_i, cr_ready_o;
    port_mask_t cd_valid_i, cd_ready_o, cd_last_i;
    addr_t ac_addr_o;
    snoop_t ac_snoop_o;
    cr_resp_t [NP-1:0] cr_resp_i;
    data_t [NP-1:0] cd_data_i;
    logic mem_ar_valid_o, mem_ar_ready_i, mem_ar_len_o;
    logic mem_r_valid_i, mem_r_ready_o, mem_r_last_i;
    addr_t mem_ar_addr_o;
    id_t mem_ar_id_o;
    data_t mem_r_data_i;

    // stimulus table
    port_idx_t t_init [NROWS];
    addr_t     t_addr [NROWS];
    logic [3:0] t_sid [NROWS];
    logic      t_len [NROWS];
    snoop_t    t_snoop [NROWS];
    cr_resp_t  t_resp [NROWS][NP];
    data_t     t_line [NROWS][NP][2];
    data_t     t_mem [NROWS][2];

    logic [31:0] lfsr_q = 32'h7f970025;
    int errors = 0;
    int checks = 0;
    int cur = 0;
    bit row_req = 0;
    bit row_done = 0;
    data_t exp_q [$];
    logic exp_sh, exp_dt;
    int exp_mem;
    int rx_beats, mem_reqs, ar_pulses, ar_cyc;
    int snoops [NP];

    ccu_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // one LFSR step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA3000000) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic set_row(input int i, input int init, input addr_t addr, input int sid,
                           input logic len, input snoop_t snp, input cr_resp_t r0,
                           input cr_resp_t r1, input cr_resp_t r2, input cr_resp_t r3);
        t_init[i]  = port_idx_t'(init);
        t_addr[i]  = addr;
        t_sid[i]   = 4'(sid);
        t_len[i]   = len;
        t_snoop[i] = snp;
        t_resp[i][0] = r0;
        t_resp[i][1] = r1;
        t_resp[i][2] = r2;
        t_resp[i][3] = r3;
        for (int n = 0; n < NP; n++) begin
            for (int w = 0; w < 2; w++) begin
                t_line[i][n][w] = {16'hCAFE, 16'(i), 16'(n), 16'(w)};
            end
        end
        t_mem[i][0] = {16'hBEEF, 16'(i), 32'd0};
        t_mem[i][1] = {16'hBEEF, 16'(i), 32'd1};
    endtask

    // --------------------------------------------------------------------------
    // snoop masters, memory and requester back-pressure
    // --------------------------------------------------------------------------
    initial begin
        int stage [NP];
        int dly [NP];
        int snp_dly;
        int data_dly;
        port_mask_t ac_hs, cr_hs, cd_hs, ac_seen;
        logic mem_ar_hs, mem_r_hs;
        int mem_idx;
        bit mem_pend;
        mem_idx = 0;
        mem_pend = 0;
        snp_dly = 0;
        data_dly = 0;
        for (int n = 0; n < NP; n++) begin
            stage[n] = 0;
            dly[n] = 0;
        end
        forever begin
            @(negedge clk_i);
            if (row_req) begin
                // one delay per row for all masters
                snp_dly = rand_bits(2);
                data_dly = rand_bits(2);
                for (int n = 0; n < NP; n++) begin
                    stage[n] = 0;
                    dly[n] = snp_dly;
                    snoops[n] = 0;
                end
                mem_pend = 0;
                rx_beats = 0;
                mem_reqs = 0;
                ar_pulses = 0;
                ar_cyc = 0;
            end
            if (ar_valid_i && ar_pulses == 0) ar_cyc++;
            if (ar_ready_o) begin
                ar_pulses++;
                check_eq(64'(ar_cyc), 64'd2, "ar_ready timing");
            end
            check_eq(64'(ac_valid_o[t_init[cur]]), 64'd0, "initiator snooped");
            ac_seen = ac_valid_o;
            ac_hs = ac_valid_o & ac_ready_i;
            cr_hs = cr_valid_i & cr_ready_o;
            cd_hs = cd_valid_i & cd_ready_o;
            mem_ar_hs = mem_ar_valid_o && mem_ar_ready_i;
            mem_r_hs = mem_r_valid_i && mem_r_ready_o;
            for (int n = 0; n < NP; n++) begin
                if (ac_hs[n]) begin
                    snoops[n]++;
                    check_eq(64'(ac_addr_o), 64'(t_addr[cur]), "snoop address");
                    check_eq(64'(ac_snoop_o), 64'(t_snoop[cur]), "snoop opcode");
                end
            end
            if (r_valid_o && r_ready_i) begin
                if (rx_beats < exp_q.size()) begin
                    check_eq(r_data_o, exp_q[rx_beats], "r data");
                    check_eq(64'(r_last_o), 64'(rx_beats == exp_q.size() - 1), "r last");
                end else begin
                    check_eq(64'd1, 64'd0, "extra r beat");
                end
                check_eq(64'(r_id_o), 64'({t_init[cur], t_sid[cur]}), "r id");
                check_eq(64'(r_shared_o), 64'(exp_sh), "r shared");
                check_eq(64'(r_dirty_o), 64'(exp_dt), "r dirty");
                rx_beats++;
                if (r_last_o) row_done = 1;
            end
            if (mem_ar_hs) begin
                mem_reqs++;
                check_eq(64'(mem_ar_addr_o), 64'(t_addr[cur]), "memory address");
                check_eq(64'(mem_ar_id_o), 64'({t_init[cur], t_sid[cur]}), "memory id");
                check_eq(64'(mem_ar_len_o), 64'(t_len[cur]), "memory len");
                mem_pend = 1;
                mem_idx = 0;
            end
            if (mem_r_hs) mem_idx++;

            @(posedge clk_i);
            #2;
            for (int n = 0; n < NP; n++) begin
                cr_resp_i[n] = t_resp[cur][n];
                case (stage[n])
                    0: begin
                        if (ac_hs[n]) begin
                            ac_ready_i[n] = 1'b0;
                            cr_valid_i[n] = 1'b1;
                            stage[n] = 1;
                        end else if (ac_seen[n]) begin
                            if (dly[n] == 0) ac_ready_i[n] = 1'b1;
                            else dly[n]--;
                        end
                    end
                    1: begin
                        if (cr_hs[n]) begin
                            cr_valid_i[n] = 1'b0;
                            dly[n] = data_dly;
                            stage[n] = t_resp[cur][n].data_transfer ? 2 : 5;
                        end
                    end
                    2: begin
                        if (dly[n] == 0) begin
                            cd_valid_i[n] = 1'b1;
                            cd_data_i[n] = t_line[cur][n][0];
                            cd_last_i[n] = 1'b0;
                            stage[n] = 3;
                        end else begin
                            dly[n]--;
                        end
                    end
                    3: begin
                        if (cd_hs[n]) begin
                            cd_data_i[n] = t_line[cur][n][1];
                            cd_last_i[n] = 1'b1;
                            stage[n] = 4;
                        end
                    end
                    4: begin
                        if (cd_hs[n]) begin
                            cd_valid_i[n] = 1'b0;
                            cd_last_i[n] = 1'b0;
                            stage[n] = 5;
                        end
                    end
                    default: begin
                        cd_valid_i[n] = 1'b0;
                        ac_ready_i[n] = 1'b0;
                        cr_valid_i[n] = 1'b0;
                    end
                endcase
            end
            if (mem_pend && mem_idx > int'(t_len[cur])) mem_pend = 0;
            mem_r_valid_i = mem_pend;
            mem_r_data_i = t_mem[cur][mem_idx % 2];
            mem_r_last_i = (mem_idx == int'(t_len[cur]));
            mem_ar_ready_i = 1'(rand_bits(1));
            r_ready_i = (rand_bits(2) != 0);
        end
    end

    // watchdog
    initial begin
        #((5 + NROWS * 200) * 20);
        $display("test timed out before all rows completed");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int dm;
        rst_ni = 1'b0;
        ar_valid_i = 1'b0;
        ar_addr_i = '0;
        ar_id_i = '0;
        ar_len_i = 1'b0;
        ar_snoop_i = '0;
        r_ready_i = 1'b0;
        ac_ready_i = '0;
        cr_valid_i = '0;
        cr_resp_i = '0;
        cd_valid_i = '0;
        cd_data_i = '0;
        cd_last_i = '0;
        mem_ar_ready_i = 1'b0;
        mem_r_valid_i = 1'b0;
        mem_r_data_i = '0;
        mem_r_last_i = 1'b0;
        // resp bits are data_transfer, error, pass_dirty, is_shared, was_unique
        set_row(0, 0, 32'h1000_0040, 3, 1'b1, 4'h1, 5'b00000, 5'b10010, 5'b10100, 5'b00010);
        set_row(1, 2, 32'h0000_2008, 5, 1'b0, 4'h2, 5'b11000, 5'b00000, 5'b00000, 5'b10001);
        set_row(2, 1, 32'h0000_3000, 9, 1'b0, 4'h1, 5'b10000, 5'b00000, 5'b00010, 5'b00000);
        set_row(3, 3, 32'h0000_4010, 2, 1'b1, 4'h7, 5'b00000, 5'b00010, 5'b00100, 5'b00000);
        set_row(4, 0, 32'h0000_5018, 1, 1'b0, 4'h1, 5'b00000, 5'b11000, 5'b11010, 5'b00100);
        set_row(5, 1, 32'h0000_6020, 15, 1'b1, 4'h3, 5'b10110, 5'b00000, 5'b10000, 5'b10100);

        repeat (5) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_eq(64'(ar_ready_o), 64'd0, "ar_ready after reset");
        check_eq(64'(r_valid_o), 64'd0, "r_valid after reset");
        check_eq(64'(mem_ar_valid_o), 64'd0, "mem_ar_valid after reset");
        check_eq(64'(ac_valid_o), 64'd0, "ac_valid after reset");

        for (int i = 0; i < NROWS; i++) begin
            @(posedge clk_i);
            #2;
            cur = i;
            dm = -1;
            exp_sh = 1'b0;
            exp_dt = 1'b0;
            for (int n = 0; n < NP; n++) begin
                if (n != int'(t_init[i])) begin
                    exp_sh |= t_resp[i][n].is_shared;
                    exp_dt |= t_resp[i][n].pass_dirty;
                    if (dm < 0 && t_resp[i][n].data_transfer && !t_resp[i][n].error) dm = n;
                end
            end
            exp_q.delete();
            if (dm >= 0) begin
                exp_mem = 0;
                if (t_len[i]) begin
                    exp_q.push_back(t_line[i][dm][0]);
                    exp_q.push_back(t_line[i][dm][1]);
                end else begin
                    exp_q.push_back(t_line[i][dm][t_addr[i][`CCU_OFFSET_BIT]]);
                end
            end else begin
                exp_mem = 1;
                exp_sh = 1'b0;
                exp_dt = 1'b0;
                exp_q.push_back(t_mem[i][0]);
                if (t_len[i]) exp_q.push_back(t_mem[i][1]);
            end
            row_done = 0;
            row_req = 1;
            @(posedge clk_i);
            #2;
            row_req = 0;
            ar_addr_i = t_addr[i];
            ar_id_i = {t_init[i], t_sid[i]};
            ar_len_i = t_len[i];
            ar_snoop_i = t_snoop[i];
            ar_valid_i = 1'b1;
            while (ar_pulses == 0) @(posedge clk_i);
            #2;
            ar_valid_i = 1'b0;
            while (!row_done) @(posedge clk_i);
            repeat (2) @(posedge clk_i);
            check_eq(64'(rx_beats), 64'(exp_q.size()), "r beat count");
            check_eq(64'(mem_reqs), 64'(exp_mem), "memory request count");
            check_eq(64'(ar_pulses), 64'd1, "ar_ready pulse count");
            for (int n = 0; n < NP; n++) begin
                check_eq(64'(snoops[n]), 64'(n != int'(t_init[i])), "snoop count");
            end
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== design/ccu_top.sv ====
`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_top import ccu_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    // requester
    input  logic                          ar_valid_i,
    output logic                          ar_ready_o,
    input  addr_t                         ar_addr_i,
    input  id_t                           ar_id_i,
    input  logic                          ar_len_i,
    input  snoop_t                        ar_snoop_i,
    output logic                          r_valid_o,
    input  logic                          r_ready_i,
    output data_t                         r_data_o,
    output id_t                           r_id_o,
    output logic                          r_last_o,
    output logic                          r_shared_o,
    output logic                          r_dirty_o,
    // snoop masters
    output port_mask_t                    ac_valid_o,
    input  port_mask_t                    ac_ready_i,
    output addr_t                         ac_addr_o,
    output snoop_t                        ac_snoop_o,
    input  port_mask_t                    cr_valid_i,
    output port_mask_t                    cr_ready_o,
    input  cr_resp_t [`CCU_NUM_PORTS-1:0] cr_resp_i,
    input  port_mask_t                    cd_valid_i,
    output port_mask_t                    cd_ready_o,
    input  data_t [`CCU_NUM_PORTS-1:0]    cd_data_i,
    input  port_mask_t                    cd_last_i,
    // memory
    output logic                          mem_ar_valid_o,
    input  logic                          mem_ar_ready_i,
    output addr_t                         mem_ar_addr_o,
    output id_t                           mem_ar_id_o,
    output logic                          mem_ar_len_o,
    input  logic                          mem_r_valid_i,
    output logic                          mem_r_ready_o,
    input  data_t                         mem_r_data_i,
    input  logic                          mem_r_last_i
);

    ccu_state_e state;
    logic       snoop_done;
    logic       resp_done;
    logic       data_found;
    port_mask_t data_avail;
    port_idx_t  first_responder;
    logic       shared;
    logic       dirty;
    port_idx_t  initiator;
    addr_t      req_addr;
    id_t        req_id;
    logic       req_len;
    snoop_t     req_snoop;
    logic       store;
    data_t      word;
    logic       word_valid;
    beat_cnt_t  stored;
    logic       beat_idx;
    logic       beat_last;
    logic       eot;
    logic       in_snp;
    logic       in_mem;
    logic       snp_send;

    ccu_read_fsm u_fsm (
        .clk_i, .rst_ni, .ar_valid_i,
        .snoop_done_i (snoop_done),
        .resp_done_i  (resp_done),
        .data_found_i (data_found),
        .mem_ar_ready_i, .mem_r_valid_i, .mem_r_last_i, .r_ready_i,
        .eot_i        (eot),
        .state_o      (state),
        .ar_ready_o, .mem_ar_valid_o, .mem_r_ready_o
    );

    ccu_snoop_collector u_collector (
        .clk_i, .rst_ni,
        .state_i           (state),
        .initiator_i       (initiator),
        .ac_ready_i, .cr_valid_i, .cr_resp_i, .ac_valid_o, .cr_ready_o,
        .snoop_done_o      (snoop_done),
        .resp_done_o       (resp_done),
        .data_found_o      (data_found),
        .data_avail_o      (data_avail),
        .first_responder_o (first_responder),
        .shared_o          (shared),
        .dirty_o           (dirty)
    );

    ccu_beat_counter u_counter (
        .clk_i, .rst_ni,
        .state_i    (state),
        .store_i    (store),
        .send_i     (snp_send),
        .len_i      (req_len),
        .stored_o   (stored),
        .beat_idx_o (beat_idx),
        .last_o     (beat_last),
        .eot_o      (eot)
    );

    ccu_line_buffer u_buffer (
        .clk_i, .rst_ni,
        .state_i           (state),
        .ar_valid_i, .ar_addr_i, .ar_id_i, .ar_len_i, .ar_snoop_i,
        .data_avail_i      (data_avail),
        .first_responder_i (first_responder),
        .cd_valid_i, .cd_data_i, .cd_last_i,
        .stored_i          (stored),
        .beat_idx_i        (beat_idx),
        .req_addr_o        (req_addr),
        .req_id_o          (req_id),
        .req_len_o         (req_len),
        .req_snoop_o       (req_snoop),
        .initiator_o       (initiator),
        .cd_ready_o,
        .store_o           (store),
        .word_o            (word),
        .word_valid_o      (word_valid)
    );

    // ------------------------------------------------------------------------
    // r channel source select
    // ------------------------------------------------------------------------
    assign in_snp   = (state == READ_SNP_DATA);
    assign in_mem   = (state == READ_MEM);
    assign snp_send = in_snp && word_valid && r_ready_i;

    assign r_valid_o  = in_mem ? mem_r_valid_i : (in_snp && word_valid);
    assign r_data_o   = in_mem ? mem_r_data_i : word;
    assign r_last_o   = in_mem ? mem_r_last_i : beat_last;
    assign r_id_o     = req_id;
    // flags only come with snooped data
    assign r_shared_o = in_snp && shared;
    assign r_dirty_o  = in_snp && dirty;

    assign ac_addr_o     = req_addr;
    assign ac_snoop_o    = req_snoop;
    assign mem_ar_addr_o = req_addr;
    assign mem_ar_id_o   = req_id;
    assign mem_ar_len_o  = req_len;

endmodule

// ==== design/ccu_line_buffer.sv ====
`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_line_buffer import ccu_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  ccu_state_e                 state_i,
    input  logic                       ar_valid_i,
    input  addr_t                      ar_addr_i,
    input  id_t                        ar_id_i,
    input  logic                       ar_len_i,
    input  snoop_t                     ar_snoop_i,
    input  port_mask_t                 data_avail_i,
    input  port_idx_t                  first_responder_i,
    input  port_mask_t                 cd_valid_i,
    input  data_t [`CCU_NUM_PORTS-1:0] cd_data_i,
    input  port_mask_t                 cd_last_i,
    input  beat_cnt_t                  stored_i,
    input  logic                       beat_idx_i,
    output addr_t                      req_addr_o,
    output id_t                        req_id_o,
    output logic                       req_len_o,
    output snoop_t                     req_snoop_o,
    output port_idx_t                  initiator_o,
    output port_mask_t                 cd_ready_o,
    output logic                       store_o,
    output data_t                      word_o,
    output logic                       word_valid_o
);

    addr_t      req_addr_q;
    id_t        req_id_q;
    logic       req_len_q;
    snoop_t     req_snoop_q;
    data_t      line_q [`CCU_LINE_WORDS];
    port_mask_t cd_done_q;
    logic       drain_en;
    logic       word_idx;

    // request and line storage
    always_ff @(posedge clk_i) begin
        if (state_i == IDLE && ar_valid_i) begin
            req_addr_q  <= ar_addr_i;
            req_id_q    <= ar_id_i;
            req_len_q   <= ar_len_i;
            req_snoop_q <= ar_snoop_i;
        end
        if (store_o) begin
            line_q[stored_i[0]] <= cd_data_i[first_responder_i];
        end
    end

    // per-port end of snoop data
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cd_done_q <= '0;
        end else if (state_i == IDLE) begin
            cd_done_q <= '0;
        end else begin
            cd_done_q <= cd_done_q | (cd_valid_i & cd_ready_o & cd_last_i);
        end
    end

    // other data carriers are drained and dropped, also on the memory path
    assign drain_en   = state_i inside {READ_SNP_DATA, SEND_MEM_REQ, READ_MEM};
    assign cd_ready_o = drain_en ? (data_avail_i & ~cd_done_q) : '0;
    assign store_o    = (state_i == READ_SNP_DATA) && cd_valid_i[first_responder_i]
                        && cd_ready_o[first_responder_i];

    // critical word for single reads, beat order for lines
    assign word_idx     = req_len_q ? beat_idx_i : req_addr_q[`CCU_OFFSET_BIT];
    assign word_o       = line_q[word_idx];
    assign word_valid_o = ({1'b0, word_idx} < stored_i);

    assign req_addr_o  = req_addr_q;
    assign req_id_o    = req_id_q;
    assign req_len_o   = req_len_q;
    assign req_snoop_o = req_snoop_q;
    assign initiator_o = req_id_q[`CCU_SLV_ID_W +: `CCU_IDX_W];

endmodule

// ==== design/ccu_beat_counter.sv ====
`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_beat_counter import ccu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  ccu_state_e state_i,
    input  logic       store_i,
    input  logic       send_i,
    input  logic       len_i,
    output beat_cnt_t  stored_o,
    output logic       beat_idx_o,
    output logic       last_o,
    output logic       eot_o
);

    beat_cnt_t stored_q;
    logic      beat_q;
    logic      eot_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stored_q <= '0;
            beat_q   <= 1'b0;
            eot_q    <= 1'b0;
        end else if (state_i == IDLE) begin
            stored_q <= '0;
            beat_q   <= 1'b0;
            eot_q    <= 1'b0;
        end else begin
            if (store_i) begin
                stored_q <= stored_q + beat_cnt_t'(1);
            end
            if (send_i) begin
                beat_q <= ~beat_q;
                if (last_o) begin
                    eot_q <= 1'b1;
                end
            end
        end
    end

    assign stored_o   = stored_q;
    assign beat_idx_o = beat_q;
    // second word of a line, or the only beat of a single read
    assign last_o     = len_i ? (beat_q == 1'(`CCU_LINE_WORDS - 1)) : 1'b1;
    assign eot_o      = eot_q | (send_i & last_o);

endmodule

// ==== design/ccu_snoop_collector.sv ====
`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_snoop_collector import ccu_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  ccu_state_e                    state_i,
    input  port_idx_t                     initiator_i,
    input  port_mask_t                    ac_ready_i,
    input  port_mask_t                    cr_valid_i,
    input  cr_resp_t [`CCU_NUM_PORTS-1:0] cr_resp_i,
    output port_mask_t                    ac_valid_o,
    output port_mask_t                    cr_ready_o,
    output logic                          snoop_done_o,
    output logic                          resp_done_o,
    output logic                          data_found_o,
    output port_mask_t                    data_avail_o,
    output port_idx_t                     first_responder_o,
    output logic                          shared_o,
    output logic                          dirty_o
);

    port_mask_t init_mask;
    port_mask_t ac_done_q;
    port_mask_t cr_done_q;
    port_mask_t ac_hs;
    port_mask_t cr_hs;
    logic       issue_q;
    port_mask_t avail_q;
    port_mask_t error_q;
    port_mask_t shared_q;
    port_mask_t dirty_q;
    logic       found_q;
    port_idx_t  first_q;
    logic       pick_valid;
    port_idx_t  pick_idx;

    assign init_mask = port_mask_t'(1) << initiator_i;

    // snoops go out one cycle into SEND_SNOOP
    assign ac_valid_o = (state_i == SEND_SNOOP && issue_q) ? ~ac_done_q : '0;
    assign cr_ready_o = (state_i == WAIT_RESP) ? ~cr_done_q : '0;
    assign ac_hs      = ac_valid_o & ac_ready_i;
    assign cr_hs      = cr_ready_o & cr_valid_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            issue_q   <= 1'b0;
            ac_done_q <= '0;
            cr_done_q <= '0;
        end else begin
            issue_q <= (state_i == SEND_SNOOP);
            case (state_i)
                // initiator counts as done from the start
                DECODE: begin
                    ac_done_q <= init_mask;
                    cr_done_q <= init_mask;
                end
                SEND_SNOOP: ac_done_q <= ac_done_q | ac_hs;
                WAIT_RESP:  cr_done_q <= cr_done_q | cr_hs;
                default: begin
                end
            endcase
        end
    end

    // lowest index wins among responders in the same cycle
    always_comb begin
        pick_valid = 1'b0;
        pick_idx   = '0;
        for (int n = `CCU_NUM_PORTS - 1; n >= 0; n--) begin
            if (cr_hs[n] && cr_resp_i[n].data_transfer && !cr_resp_i[n].error) begin
                pick_valid = 1'b1;
                pick_idx   = port_idx_t'(n);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            avail_q  <= '0;
            error_q  <= '0;
            shared_q <= '0;
            dirty_q  <= '0;
            found_q  <= 1'b0;
            first_q  <= '0;
        end else if (state_i == IDLE) begin
            avail_q  <= '0;
            error_q  <= '0;
            shared_q <= '0;
            dirty_q  <= '0;
            found_q  <= 1'b0;
            first_q  <= '0;
        end else begin
            for (int n = 0; n < `CCU_NUM_PORTS; n++) begin
                if (cr_hs[n]) begin
                    avail_q[n]  <= cr_resp_i[n].data_transfer;
                    error_q[n]  <= cr_resp_i[n].error;
                    shared_q[n] <= cr_resp_i[n].is_shared;
                    dirty_q[n]  <= cr_resp_i[n].pass_dirty;
                end
            end
            if (!found_q && pick_valid) begin
                found_q <= 1'b1;
                first_q <= pick_idx;
            end
        end
    end

    assign snoop_done_o      = &ac_done_q;
    assign resp_done_o       = &cr_done_q;
    assign data_found_o      = |(avail_q & ~error_q);
    assign data_avail_o      = avail_q;
    assign first_responder_o = first_q;
    assign shared_o          = |shared_q;
    assign dirty_o           = |dirty_q;

endmodule

// ==== design/ccu_read_fsm.sv ====
`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_read_fsm import ccu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       ar_valid_i,
    input  logic       snoop_done_i,
    input  logic       resp_done_i,
    input  logic       data_found_i,
    input  logic       mem_ar_ready_i,
    input  logic       mem_r_valid_i,
    input  logic       mem_r_last_i,
    input  logic       r_ready_i,
    input  logic       eot_i,
    output ccu_state_e state_o,
    output logic       ar_ready_o,
    output logic       mem_ar_valid_o,
    output logic       mem_r_ready_o
);

    ccu_state_e state_d;
    ccu_state_e state_q;

    // ------------------------------------------------------------------------
    // state register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (ar_valid_i) begin
                    state_d = DECODE;
                end
            end
            DECODE: begin
                state_d = SEND_SNOOP;
            end
            SEND_SNOOP: begin
                // all non-initiator masters took the snoop address
                if (snoop_done_i) begin
                    state_d = WAIT_RESP;
                end
            end
            WAIT_RESP: begin
                if (resp_done_i) begin
                    state_d = data_found_i ? READ_SNP_DATA : SEND_MEM_REQ;
                end
            end
            READ_SNP_DATA: begin
                if (eot_i) begin
                    state_d = IDLE;
                end
            end
            SEND_MEM_REQ: begin
                if (mem_ar_ready_i) begin
                    state_d = READ_MEM;
                end
            end
            READ_MEM: begin
                // last memory beat accepted by the requester
                if (mem_r_valid_i && r_ready_i && mem_r_last_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign state_o        = state_q;
    assign ar_ready_o     = (state_q == DECODE);
    assign mem_ar_valid_o = (state_q == SEND_MEM_REQ);
    // memory data flows straight through to the requester
    assign mem_r_ready_o  = (state_q == READ_MEM) && r_ready_i;

endmodule

// ==== design/ccu_pkg.sv ====
`include "ccu_defines.svh"

package ccu_pkg;

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        SEND_SNOOP,
        WAIT_RESP,
        READ_SNP_DATA,
        SEND_MEM_REQ,
        READ_MEM
    } ccu_state_e;

    // snoop response flags
    typedef struct packed {
        logic data_transfer;
        logic error;
        logic pass_dirty;
        logic is_shared;
        logic was_unique;
    } cr_resp_t;

    typedef logic [`CCU_NUM_PORTS-1:0] port_mask_t;
    typedef logic [`CCU_IDX_W-1:0]     port_idx_t;
    typedef logic [`CCU_ADDR_W-1:0]    addr_t;
    typedef logic [`CCU_DATA_W-1:0]    data_t;
    typedef logic [`CCU_ID_W-1:0]      id_t;
    typedef logic [3:0]                snoop_t;
    typedef logic [1:0]                beat_cnt_t;

endpackage

// ==== design/ccu_defines.svh ====
`ifndef CCU_DEFINES_SVH
`define CCU_DEFINES_SVH

// cached masters behind the unit
`define CCU_NUM_PORTS 4

// bus widths
`define CCU_ADDR_W 32
`define CCU_DATA_W 64

// id layout, master index sits above the per-master id
`define CCU_SLV_ID_W 4
`define CCU_IDX_W 2
`define CCU_ID_W 6

// cache line geometry
`define CCU_LINE_WORDS 2
`define CCU_OFFSET_BIT 3

`endif
